// File: hdl/pif_defines.svh
`ifndef PIF_DEFINES_SVH
`define PIF_DEFINES_SVH

// ---------------------------------------------------------------------------
// received byte layout: tag in the top bits, payload below
`define PIF_DATA_BITS   6
`define PIF_TAG_BITS    2

// parallel side widths
`define PIF_ADDR_W      4
`define PIF_SUBA_W      7

// wishbone widths
`define WB_DATA_W       8
`define WB_ADDR_W       8

// byte tags
`define TAG_ADDR        2'b01
`define TAG_DATA        2'b10

// primary i2c slave register map
`define EFB_CMDR        8'h41
`define EFB_TXDR        8'h44
`define EFB_SR          8'h45
`define EFB_RXDR        8'h47

// status register bits
// TIP | BUSY | RARC | SRW | ARBL | TRRDY | TROE | HGC
`define SR_TIP          7
`define SR_BUSY         6
`define SR_RARC         5
`define SR_SRW          4
`define SR_TRRDY        2
`define SR_TROE         1

// command register values, clock stretch control
`define CMD_STRETCH_OFF 8'h04
`define CMD_STRETCH_ON  8'h00

`endif

// File: hdl/pif_pkg.sv
`include "pif_defines.svh"

package pif_pkg;

    // -----------------------------------------------------------------------
    // sequencer states
    // each access state also has a waiting phase, tracked beside the state
    typedef enum logic [3:0] {
        stStart,
        stInit1,
        stInit2,
        stInit3,
        stInit4,
        stIdle,
        stWaitReady,
        stRxTake,
        stTxDone1,
        stTxDone2
    } seqState_t;

    // slave registers reached over wishbone
    typedef enum logic [`WB_ADDR_W-1:0] {
        regCmdr = `EFB_CMDR,
        regTxdr = `EFB_TXDR,
        regSr   = `EFB_SR,
        regRxdr = `EFB_RXDR
    } efbReg_t;

    // top bits of a received byte
    typedef enum logic [`PIF_TAG_BITS-1:0] {
        tagNone  = 2'b00,
        tagAddr  = `TAG_ADDR,
        tagData  = `TAG_DATA,
        tagSpare = 2'b11
    } byteTag_t;

endpackage

// File: hdl/wbBusMaster.sv
`include "pif_defines.svh"

module wbBusMaster (
    input  logic                  xclk,
    input  logic                  sys_rst,
    input  logic                  reqValid_i,
    input  logic                  reqWrite_i,
    input  pif_pkg::efbReg_t      reqAddr_i,
    input  logic [`WB_DATA_W-1:0] reqData_i,
    input  logic [`WB_DATA_W-1:0] wbDat_i,
    input  logic                  wbAck_i,
    output logic                  wbCyc_o,
    output logic                  wbStb_o,
    output logic                  wbWe_o,
    output logic [`WB_ADDR_W-1:0] wbAdr_o,
    output logic [`WB_DATA_W-1:0] wbDat_o,
    output logic [`WB_DATA_W-1:0] rdData_o,
    output logic                  cycDone_o
);

    // one classic cycle at a time
    // request latched on reqValid, held until the slave acks
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            wbCyc_o   <= 1'b0;
            wbStb_o   <= 1'b0;
            wbWe_o    <= 1'b0;
            wbAdr_o   <= '0;
            wbDat_o   <= '0;
            rdData_o  <= '0;
            cycDone_o <= 1'b0;
        end else begin
            // completion is a single pulse
            cycDone_o <= 1'b0;
            if (reqValid_i && !wbCyc_o) begin
                // open the cycle
                wbCyc_o <= 1'b1;
                wbStb_o <= 1'b1;
                wbWe_o  <= reqWrite_i;
                wbAdr_o <= reqAddr_i;
                wbDat_o <= reqData_i;
            end else if (wbCyc_o && wbAck_i) begin
                // ack seen, close and report next cycle
                wbCyc_o   <= 1'b0;
                wbStb_o   <= 1'b0;
                wbWe_o    <= 1'b0;
                cycDone_o <= 1'b1;
                // read data kept until the next read
                if (!wbWe_o) begin
                    rdData_o <= wbDat_i;
                end
            end
        end
    end

endmodule

// File: hdl/efbSequencer.sv
`include "pif_defines.svh"

module efbSequencer (
    input  logic                      xclk,
    input  logic                      sys_rst,
    input  logic                      cycDone_i,
    input  logic [`WB_DATA_W-1:0]     rdData_i,
    input  logic [`WB_DATA_W-1:0]     xo_i,
    output logic                      reqValid_o,
    output logic                      reqWrite_o,
    output pif_pkg::efbReg_t          reqAddr_o,
    output logic [`WB_DATA_W-1:0]     reqData_o,
    output logic                      addrLoad_o,
    output logic [`PIF_ADDR_W-1:0]    addrVal_o,
    output logic                      dataLoad_o,
    output logic [`PIF_DATA_BITS-1:0] dataVal_o,
    output logic                      txFinish_o
);

    import pif_pkg::*;

    seqState_t            state;
    seqState_t            stateNext;
    // set while an access is in flight
    logic                 awaitDone;
    efbReg_t              pendAddr;
    logic [`WB_DATA_W-1:0] rxByte;
    byteTag_t             rxTag;

    // held status flags
    logic                 busy;
    logic                 txReady;
    logic                 rxReady;
    logic                 lastTxNak;

    // status decode of the returned byte
    logic                 srBusy;
    logic                 srTxReady;
    logic                 srRxReady;
    logic                 srLastTxNak;

    assign srBusy      = rdData_i[`SR_BUSY];
    assign srTxReady   = rdData_i[`SR_BUSY] & rdData_i[`SR_TRRDY] &
                         rdData_i[`SR_SRW] & ~rdData_i[`SR_TIP];
    assign srRxReady   = rdData_i[`SR_BUSY] & rdData_i[`SR_TRRDY] & ~rdData_i[`SR_SRW];
    assign srLastTxNak = rdData_i[`SR_BUSY] & rdData_i[`SR_RARC] &
                         rdData_i[`SR_SRW] & rdData_i[`SR_TROE];

    // -----------------------------------------------------------------------
    // access issued on the first cycle of a state
    always_comb begin
        reqValid_o = 1'b0;
        reqWrite_o = 1'b0;
        reqAddr_o  = regSr;
        reqData_o  = '0;
        if (!awaitDone) begin
            case (state)
                stStart: begin
                    // stretch off while flushing
                    reqValid_o = 1'b1;
                    reqWrite_o = 1'b1;
                    reqAddr_o  = regCmdr;
                    reqData_o  = `CMD_STRETCH_OFF;
                end
                // status polls
                stInit1, stIdle, stRxTake, stTxDone2: begin
                    reqValid_o = 1'b1;
                end
                // two dummy receive reads
                stInit2, stInit3: begin
                    reqValid_o = 1'b1;
                    reqAddr_o  = regRxdr;
                end
                stInit4: begin
                    reqValid_o = 1'b1;
                    reqWrite_o = 1'b1;
                    reqAddr_o  = regCmdr;
                    reqData_o  = `CMD_STRETCH_ON;
                end
                stWaitReady: begin
                    // nak or bus idle issues nothing, back to start
                    if (!lastTxNak && busy) begin
                        reqValid_o = 1'b1;
                        if (txReady) begin
                            reqWrite_o = 1'b1;
                            reqAddr_o  = regTxdr;
                            reqData_o  = xo_i;
                        end else if (rxReady) begin
                            reqAddr_o = regRxdr;
                        end
                    end
                end
                default: begin
                    reqValid_o = 1'b0;
                end
            endcase
        end
    end

    // -----------------------------------------------------------------------
    // next state, on completion or directly for access-free cycles
    always_comb begin
        stateNext = state;
        if (awaitDone) begin
            if (cycDone_i) begin
                case (state)
                    stStart:     stateNext = stInit1;
                    // poll until the bus is quiet
                    stInit1:     stateNext = srBusy ? stInit1 : stInit2;
                    stInit2:     stateNext = stInit3;
                    stInit3:     stateNext = stInit4;
                    stInit4:     stateNext = stIdle;
                    // poll until a transfer starts
                    stIdle:      stateNext = srBusy ? stWaitReady : stIdle;
                    stWaitReady: begin
                        case (pendAddr)
                            regTxdr: stateNext = stTxDone1;
                            regRxdr: stateNext = stRxTake;
                            default: stateNext = stWaitReady;
                        endcase
                    end
                    // fresh status read done
                    stRxTake, stTxDone2: stateNext = stWaitReady;
                    default:     stateNext = stStart;
                endcase
            end
        end else begin
            case (state)
                stWaitReady: begin
                    if (lastTxNak || !busy) begin
                        stateNext = stStart;
                    end
                end
                stTxDone1: stateNext = stTxDone2;
                default:   stateNext = state;
            endcase
        end
    end

    // -----------------------------------------------------------------------
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            state     <= stStart;
            awaitDone <= 1'b0;
            pendAddr  <= regSr;
            busy      <= 1'b0;
            txReady   <= 1'b0;
            rxReady   <= 1'b0;
            lastTxNak <= 1'b0;
        end else begin
            state <= stateNext;
            if (reqValid_o) begin
                awaitDone <= 1'b1;
                pendAddr  <= reqAddr_o;
            end else if (cycDone_i) begin
                awaitDone <= 1'b0;
            end
            // flags follow completed status reads only
            if (cycDone_i && pendAddr == regSr) begin
                busy      <= srBusy;
                txReady   <= srTxReady;
                rxReady   <= srRxReady;
                lastTxNak <= srLastTxNak;
            end
        end
    end

    // received byte, also overwritten by the init dummy reads
    always_ff @(posedge xclk) begin
        if (cycDone_i && pendAddr == regRxdr) begin
            rxByte <= rdData_i;
        end
    end

    // tag decode and loads in the first rxTake cycle
    assign rxTag      = byteTag_t'(rxByte[`WB_DATA_W-1 -: `PIF_TAG_BITS]);
    assign addrLoad_o = (state == stRxTake) && !awaitDone && (rxTag == tagAddr);
    assign dataLoad_o = (state == stRxTake) && !awaitDone && (rxTag == tagData);
    assign addrVal_o  = rxByte[`PIF_ADDR_W-1:0];
    assign dataVal_o  = rxByte[`PIF_DATA_BITS-1:0];
    assign txFinish_o = (state == stTxDone1);

endmodule

// File: hdl/pifRegs.sv
`include "pif_defines.svh"

module pifRegs (
    input  logic                      xclk,
    input  logic                      sys_rst,
    input  logic                      addrLoad_i,
    input  logic [`PIF_ADDR_W-1:0]    addrVal_i,
    input  logic                      dataLoad_i,
    input  logic [`PIF_DATA_BITS-1:0] dataVal_i,
    input  logic                      txFinish_i,
    output logic                      xiPwr_o,
    output logic [`PIF_ADDR_W-1:0]    xiPrwa_o,
    output logic                      xiPrdFinished_o,
    output logic [`PIF_SUBA_W-1:0]    xiPrdSubA_o,
    output logic [`PIF_DATA_BITS-1:0] xiPd_o
);

    // parallel address and read sub-address
    logic [`PIF_ADDR_W-1:0]    rwAddr;
    logic [`PIF_SUBA_W-1:0]    rdSubAddr;

    // local stage ahead of the outputs
    logic                      locPwr;
    logic [`PIF_DATA_BITS-1:0] locPd;
    logic                      locFinished;

    // -----------------------------------------------------------------------
    // address byte sets the address, restarts the sub-address
    // sub-address steps once per finished read, wraps at full width
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            rwAddr    <= '0;
            rdSubAddr <= '0;
        end else begin
            if (addrLoad_i) begin
                rwAddr    <= addrVal_i;
                rdSubAddr <= '0;
            end else if (locFinished) begin
                rdSubAddr <= rdSubAddr + 1'b1;
            end
        end
    end

    // write strobe, data and finish strobe, first stage
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            locPwr      <= 1'b0;
            locPd       <= '0;
            locFinished <= 1'b0;
        end else begin
            locPwr      <= dataLoad_i;
            locFinished <= txFinish_i;
            if (dataLoad_i) begin
                locPd <= dataVal_i;
            end
        end
    end

    // -----------------------------------------------------------------------
    // output register stage
    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            xiPwr_o         <= 1'b0;
            xiPrwa_o        <= '0;
            xiPrdFinished_o <= 1'b0;
            xiPrdSubA_o     <= '0;
            xiPd_o          <= '0;
        end else begin
            xiPwr_o         <= locPwr;
            xiPrwa_o        <= rwAddr;
            xiPrdFinished_o <= locFinished;
            xiPrdSubA_o     <= rdSubAddr;
            xiPd_o          <= locPd;
        end
    end

endmodule

// File: hdl/pifWbTop.sv
`include "pif_defines.svh"

module pifWbTop (
    input  logic                      xclk,
    input  logic                      sys_rst,
    // wishbone master towards the i2c slave
    output logic                      wbCyc_o,
    output logic                      wbStb_o,
    output logic                      wbWe_o,
    output logic [`WB_ADDR_W-1:0]     wbAdr_o,
    output logic [`WB_DATA_W-1:0]     wbDat_o,
    input  logic [`WB_DATA_W-1:0]     wbDat_i,
    input  logic                      wbAck_i,
    // parallel side
    input  logic [`WB_DATA_W-1:0]     xo_i,
    output logic                      xiPwr_o,
    output logic [`PIF_ADDR_W-1:0]    xiPrwa_o,
    output logic                      xiPrdFinished_o,
    output logic [`PIF_SUBA_W-1:0]    xiPrdSubA_o,
    output logic [`PIF_DATA_BITS-1:0] xiPd_o
);

    import pif_pkg::*;

    // sequencer to bus master
    logic                      reqValid;
    logic                      reqWrite;
    efbReg_t                   reqAddr;
    logic [`WB_DATA_W-1:0]     reqData;
    logic [`WB_DATA_W-1:0]     rdData;
    logic                      cycDone;

    // sequencer to parallel registers
    logic                      addrLoad;
    logic [`PIF_ADDR_W-1:0]    addrVal;
    logic                      dataLoad;
    logic [`PIF_DATA_BITS-1:0] dataVal;
    logic                      txFinish;

    wbBusMaster uBusMaster (
        .xclk       (xclk),
        .sys_rst    (sys_rst),
        .reqValid_i (reqValid),
        .reqWrite_i (reqWrite),
        .reqAddr_i  (reqAddr),
        .reqData_i  (reqData),
        .wbDat_i    (wbDat_i),
        .wbAck_i    (wbAck_i),
        .wbCyc_o    (wbCyc_o),
        .wbStb_o    (wbStb_o),
        .wbWe_o     (wbWe_o),
        .wbAdr_o    (wbAdr_o),
        .wbDat_o    (wbDat_o),
        .rdData_o   (rdData),
        .cycDone_o  (cycDone)
    );

    efbSequencer uSequencer (
        .xclk       (xclk),
        .sys_rst    (sys_rst),
        .cycDone_i  (cycDone),
        .rdData_i   (rdData),
        .xo_i       (xo_i),
        .reqValid_o (reqValid),
        .reqWrite_o (reqWrite),
        .reqAddr_o  (reqAddr),
        .reqData_o  (reqData),
        .addrLoad_o (addrLoad),
        .addrVal_o  (addrVal),
        .dataLoad_o (dataLoad),
        .dataVal_o  (dataVal),
        .txFinish_o (txFinish)
    );

    pifRegs uPifRegs (
        .xclk            (xclk),
        .sys_rst         (sys_rst),
        .addrLoad_i      (addrLoad),
        .addrVal_i       (addrVal),
        .dataLoad_i      (dataLoad),
        .dataVal_i       (dataVal),
        .txFinish_i      (txFinish),
        .xiPwr_o         (xiPwr_o),
        .xiPrwa_o        (xiPrwa_o),
        .xiPrdFinished_o (xiPrdFinished_o),
        .xiPrdSubA_o     (xiPrdSubA_o),
        .xiPd_o          (xiPd_o)
    );

endmodule

// File: tests/pifWb_chk.sv
module pifWb_chk (
    input  logic xclk,
    input  logic sys_rst,
    input  logic cyc_i,
    input  logic stb_i,
    input  logic we_i,
    input  logic ack_i,
    input  logic pwr_i,
    input  logic fin_i
);

    // failed assertions so far
    int assertFails = 0;

    // ---------------------------------------------------------------------------
    // classic wishbone cycle
    stbInCyc: assert property (@(posedge xclk) disable iff (!sys_rst) stb_i |-> cyc_i)
        else begin
            $error("stb high outside a cycle");
            assertFails++;
        end

    // request held until the slave acks
    stbHeld: assert property (@(posedge xclk) disable iff (!sys_rst)
                              stb_i && !ack_i |=> stb_i && $stable(we_i))
        else begin
            $error("stb or we changed before ack");
            assertFails++;
        end

    // ---------------------------------------------------------------------------
    // parallel strobes are single pulses
    pwrPulse: assert property (@(posedge xclk) disable iff (!sys_rst) pwr_i |=> !pwr_i)
        else begin
            $error("write strobe longer than one cycle");
            assertFails++;
        end

    finPulse: assert property (@(posedge xclk) disable iff (!sys_rst) fin_i |=> !fin_i)
        else begin
            $error("read finished strobe longer than one cycle");
            assertFails++;
        end

endmodule

// bus cycle and parallel strobes both visible at the top level
bind pifWbTop pifWb_chk pifChk (
    .xclk    (xclk),
    .sys_rst (sys_rst),
    .cyc_i   (wbCyc_o),
    .stb_i   (wbStb_o),
    .we_i    (wbWe_o),
    .ack_i   (wbAck_i),
    .pwr_i   (xiPwr_o),
    .fin_i   (xiPrdFinished_o)
);

// File: tests/pifWbTb.sv
`include "pif_defines.svh"

module pifWbTb;

    import pif_pkg::*;

    localparam int TIMEOUT   = 40;
    localparam int NUM_TESTS = 12;

    // status register bits as masks
    localparam logic [7:0] bitTip   = 8'd1 << `SR_TIP;
    localparam logic [7:0] bitBusy  = 8'd1 << `SR_BUSY;
    localparam logic [7:0] bitRarc  = 8'd1 << `SR_RARC;
    localparam logic [7:0] bitSrw   = 8'd1 << `SR_SRW;
    localparam logic [7:0] bitTrrdy = 8'd1 << `SR_TRRDY;
    localparam logic [7:0] bitTroe  = 8'd1 << `SR_TROE;

    logic                      xclk;
    logic                      sys_rst;
    logic                      wbCyc;
    logic                      wbStb;
    logic                      wbWe;
    logic [`WB_ADDR_W-1:0]     wbAdr;
    logic [`WB_DATA_W-1:0]     wbDatOut;
    logic [`WB_DATA_W-1:0]     wbDatIn;
    logic                      wbAck;
    logic [`WB_DATA_W-1:0]     xo;
    logic                      xiPwr;
    logic [`PIF_ADDR_W-1:0]    xiPrwa;
    logic                      xiPrdFinished;
    logic [`PIF_SUBA_W-1:0]    xiPrdSubA;
    logic [`PIF_DATA_BITS-1:0] xiPd;

    int                        seed = 24913;
    int                        errors;
    int                        checks;
    bit                        hung;
    string                     curTest;

    // observed strobes since the last output check
    logic [7:0]                pwrSeen[$];
    int                        finCount;

    // reference model of the parallel side
    logic [`PIF_ADDR_W-1:0]    expAddr;
    logic [`PIF_SUBA_W-1:0]    expSubA;

    pifWbTop UUT (
        .xclk            (xclk),
        .sys_rst         (sys_rst),
        .wbCyc_o         (wbCyc),
        .wbStb_o         (wbStb),
        .wbWe_o          (wbWe),
        .wbAdr_o         (wbAdr),
        .wbDat_o         (wbDatOut),
        .wbDat_i         (wbDatIn),
        .wbAck_i         (wbAck),
        .xo_i            (xo),
        .xiPwr_o         (xiPwr),
        .xiPrwa_o        (xiPrwa),
        .xiPrdFinished_o (xiPrdFinished),
        .xiPrdSubA_o     (xiPrdSubA),
        .xiPd_o          (xiPd)
    );

    initial begin
        xclk = 1'b0;
    end

    always #2 xclk = ~xclk;

    // strobes sampled at the clock edge with values held from the cycle before
    always @(posedge xclk) begin
        if (xiPwr) begin
            pwrSeen.push_back({2'b00, xiPd});
        end
        if (xiPrdFinished) begin
            finCount++;
        end
    end

    // ---------------------------------------------------------------------------
    // compare tasks
    task automatic checkEfbReg(input string name, input efbReg_t expVal, input efbReg_t actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", curTest, name, expVal, actVal);
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] expVal,
                             input logic [7:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", curTest, name, expVal, actVal);
        end
    endtask

    task automatic checkSubA(input string name, input logic [`PIF_SUBA_W-1:0] expVal,
                             input logic [`PIF_SUBA_W-1:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", curTest, name, expVal, actVal);
        end
    endtask

    function automatic logic [7:0] rndByte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // forced bits set and excluded bits clear with the rest random
    function automatic logic [7:0] statusByte(input logic [7:0] setBits,
                                              input logic [7:0] clrBits);
        logic [7:0] noise;
        noise = rndByte();
        return setBits | (noise & ~(setBits | clrBits));
    endfunction

    // busy with nothing to do so no tx, rx or nak is possible
    function automatic logic [7:0] waitStatus();
        return statusByte(bitBusy, bitTrrdy | bitTroe);
    endfunction

    // ---------------------------------------------------------------------------
    // slave model serving one access with an ack after 0..3 extra cycles
    task automatic serveAccess(input string name, input efbReg_t expReg, input logic expWe,
                               input logic [7:0] expData, input logic [7:0] rdVal);
        int waited;
        int delay;
        if (!hung) begin
            waited = 0;
            @(negedge xclk);
            while (!(wbCyc && wbStb) && waited < TIMEOUT) begin
                @(negedge xclk);
                waited++;
            end
            if (!(wbCyc && wbStb)) begin
                hung = 1'b1;
                errors++;
                $display("%s: bus cycle for %s never started", curTest, name);
            end else begin
                checkEfbReg({name, " address"}, expReg, efbReg_t'(wbAdr));
                checkByte({name, " we"}, {7'b0, expWe}, {7'b0, wbWe});
                if (expWe) begin
                    checkByte({name, " data"}, expData, wbDatOut);
                end
                delay = rndByte() & 8'h03;
                repeat (delay) @(posedge xclk);
                @(posedge xclk);
                wbAck   <= 1'b1;
                wbDatIn <= rdVal;
                @(posedge xclk);
                wbAck   <= 1'b0;
            end
        end
    endtask

    // outputs against the model before a fresh window starts
    task automatic checkOutputs(input string name, input int expPwr, input logic [7:0] expPd,
                                input int expFin);
        if (!hung) begin
            @(negedge xclk);
            checkByte({name, " write strobes"}, expPwr, pwrSeen.size());
            if (expPwr == 1 && pwrSeen.size() == 1) begin
                checkByte({name, " xiPd"}, expPd, pwrSeen[0]);
            end
            checkByte({name, " finish strobes"}, expFin, finCount);
            checkByte({name, " xiPrwa"}, expAddr, xiPrwa);
            checkSubA({name, " xiPrdSubA"}, expSubA, xiPrdSubA);
        end
        pwrSeen.delete();
        finCount = 0;
    endtask

    // ---------------------------------------------------------------------------
    // slave init sequence and idle polls up to the first busy status
    task automatic runInit();
        int polls;
        serveAccess("stretch off", regCmdr, 1'b1, `CMD_STRETCH_OFF, 8'h00);
        polls = rndByte() & 8'h03;
        repeat (polls) serveAccess("init busy poll", regSr, 1'b0, 8'h00, waitStatus());
        serveAccess("init quiet poll", regSr, 1'b0, 8'h00, statusByte(8'h00, bitBusy));
        serveAccess("flush read 1", regRxdr, 1'b0, 8'h00, rndByte());
        serveAccess("flush read 2", regRxdr, 1'b0, 8'h00, rndByte());
        serveAccess("stretch on", regCmdr, 1'b1, `CMD_STRETCH_ON, 8'h00);
        polls = rndByte() & 8'h03;
        repeat (polls) serveAccess("idle poll", regSr, 1'b0, 8'h00, statusByte(8'h00, bitBusy));
        serveAccess("idle exit", regSr, 1'b0, 8'h00, waitStatus());
    endtask

    // received byte as rx status, RXDR read and follow-up status read
    task automatic runRx(input logic [7:0] rxByte);
        byteTag_t tag;
        serveAccess("rx status", regSr, 1'b0, 8'h00, statusByte(bitBusy | bitTrrdy, bitSrw));
        serveAccess("rx read", regRxdr, 1'b0, 8'h00, rxByte);
        serveAccess("rx follow poll", regSr, 1'b0, 8'h00, waitStatus());
        tag = byteTag_t'(rxByte[`WB_DATA_W-1 -: `PIF_TAG_BITS]);
        // address byte restarts the read sub-address
        if (tag == tagAddr) begin
            expAddr = rxByte[`PIF_ADDR_W-1:0];
            expSubA = '0;
        end
        checkOutputs("rx", (tag == tagData) ? 1 : 0, {2'b00, rxByte[`PIF_DATA_BITS-1:0]}, 0);
    endtask

    // transmit request with xo set ahead of tx status, TXDR write and follow-up status read
    task automatic runTx();
        logic [7:0] txByte;
        txByte = rndByte();
        @(posedge xclk);
        xo <= txByte;
        serveAccess("tx status", regSr, 1'b0, 8'h00,
                    statusByte(bitBusy | bitTrrdy | bitSrw, bitTip | bitTroe));
        serveAccess("tx write", regTxdr, 1'b1, txByte, 8'h00);
        serveAccess("tx follow poll", regSr, 1'b0, 8'h00, waitStatus());
        expSubA = expSubA + 1'b1;
        checkOutputs("tx", 0, 8'h00, 1);
    endtask

    // ---------------------------------------------------------------------------
    initial begin
        int testIdx;
        int items;
        int itemIdx;
        int prevErrors;
        int assertFails;
        sys_rst  = 1'b0;
        wbAck    = 1'b0;
        wbDatIn  = '0;
        xo       = '0;
        errors   = 0;
        checks   = 0;
        hung     = 1'b0;
        finCount = 0;
        expAddr  = '0;
        expSubA  = '0;
        curTest  = "reset";
        repeat (8) @(posedge xclk);
        sys_rst <= 1'b1;

        testIdx = 0;
        while (testIdx < NUM_TESTS && !hung) begin
            curTest    = $sformatf("test %0d", testIdx);
            prevErrors = errors;
            runInit();
            items = 1 + (rndByte() & 8'h03);
            for (itemIdx = 0; itemIdx < items; itemIdx++) begin
                if ((rndByte() & 8'h03) == 0) begin
                    runTx();
                end else begin
                    runRx(rndByte());
                end
            end
            // end of transfer by nak or by the bus going idle
            if (rndByte() & 8'h01) begin
                serveAccess("nak status", regSr, 1'b0, 8'h00,
                            statusByte(bitBusy | bitRarc | bitSrw | bitTroe, 8'h00));
            end else begin
                serveAccess("bus idle status", regSr, 1'b0, 8'h00, statusByte(8'h00, bitBusy));
            end
            $display("%s finished, %0d transactions, %0d errors", curTest, items,
                     errors - prevErrors);
            testIdx++;
        end

        assertFails = UUT.pifChk.assertFails;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 testIdx, checks, errors, assertFails);
        if (errors == 0 && assertFails == 0 && !hung) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/pif_pkg.sv
hdl/wbBusMaster.sv
hdl/efbSequencer.sv
hdl/pifRegs.sv
hdl/pifWbTop.sv
tests/pifWb_chk.sv
tests/pifWbTb.sv
